//--- hdl/i2c_eeprom_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// shared constants for the 24C64-class EEPROM controller
////////////////////////////////////////////////////////////

package i2c_eeprom_pkg;

    // byte address, 8 KiB device
    localparam int EEPROM_ADDR_W = 13;

    // data byte width
    localparam int BYTE_W = 8;

    // device type code, first nibble of every control byte
    localparam logic [3:0] CTRL_CODE = 4'b1010;

    // low bit of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // control byte layout
    //   [7:4] CTRL_CODE
    //   [3:1] chip select
    //   [0]   direction
    // high address byte carries addr[12:8], upper 3 bits zero

endpackage : i2c_eeprom_pkg

`default_nettype wire

//--- hdl/scl_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module scl_timing_gen #(
    parameter int CLK_DIV = 25  // sys_clk cycles per scl period
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    output logic scl,
    output logic high_mid,
    output logic low_mid
);

    localparam int CNT_W = $clog2(CLK_DIV);
    localparam int HALF  = CLK_DIV / 2;

    localparam logic [CNT_W-1:0] CNT_LAST    = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_HALF    = CNT_W'(HALF);
    localparam logic [CNT_W-1:0] HIGH_MID_AT = CNT_W'(HALF / 2);
    localparam logic [CNT_W-1:0] LOW_MID_AT  = CNT_W'(HALF + (CLK_DIV - HALF) / 2);

    // below 8 the quarter points collapse onto the scl edges
    if (CLK_DIV < 8) begin : g_div_check
        $error("scl_timing_gen: CLK_DIV must be at least 8");
    end

    logic [CNT_W-1:0] cnt;

    // free-running phase counter
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt <= '0;
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // scl and strobes, all registered off the same count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            scl      <= 1'b1;  // bus idle
            high_mid <= 1'b0;
            low_mid  <= 1'b0;
        end else begin
            scl      <= (cnt < CNT_HALF);      // high first half, low second
            high_mid <= (cnt == HIGH_MID_AT);
            low_mid  <= (cnt == LOW_MID_AT);
        end
    end

    // master relies on strictly separate launch and sample points
    a_strobes_exclusive: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !(high_mid && low_mid)
    ) else $error("scl_timing_gen: high_mid and low_mid overlap");

endmodule : scl_timing_gen

`default_nettype wire

//--- hdl/i2c_eeprom_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_master #(
    parameter logic [2:0] DEV_SEL = 3'b000  // chip-select pins A2..A0
) (
    input  logic                                    sys_clk,
    input  logic                                    sys_rst_n,
    input  logic                                    start,
    input  logic                                    rw,
    input  logic [i2c_eeprom_pkg::EEPROM_ADDR_W-1:0] byte_addr,
    input  logic [i2c_eeprom_pkg::BYTE_W-1:0]        wdata,
    input  logic                                    high_mid,
    input  logic                                    low_mid,
    input  logic                                    sda_in,
    output logic                                    sda_oe,
    output logic                                    busy,
    output logic                                    done,
    output logic                                    ack_err,
    output logic [i2c_eeprom_pkg::BYTE_W-1:0]        rdata
);

    localparam int ADDR_W = i2c_eeprom_pkg::EEPROM_ADDR_W;
    localparam int BW     = i2c_eeprom_pkg::BYTE_W;

    localparam logic [3:0] BITS_PER_BYTE = 4'(BW);

    localparam logic [BW-1:0] CTRL_WR =
        {i2c_eeprom_pkg::CTRL_CODE, DEV_SEL, i2c_eeprom_pkg::RW_WRITE};
    localparam logic [BW-1:0] CTRL_RD =
        {i2c_eeprom_pkg::CTRL_CODE, DEV_SEL, i2c_eeprom_pkg::RW_READ};

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,     // wait high_mid, pull sda low
        S_TX,        // shift a byte out on low_mid
        S_ACK,       // sample slave ack on high_mid
        S_RSTART,    // repeated start for the read phase
        S_RX,        // shift a byte in on high_mid
        S_NACK,      // sda left released for one bit
        S_STOP_LO,   // drive sda low ahead of the stop
        S_STOP_HI,   // release sda while scl high
        S_STOP_END   // bus free, then report
    } state_t;

    state_t      state;
    logic [3:0]  bit_cnt;
    logic [1:0]  byte_idx;  // 0 ctrl, 1 addr hi, 2 addr lo, 3 data or ctrl rd

    // request and shift registers
    logic [ADDR_W-1:0] addr_q;
    logic [BW-1:0]     wdata_q;
    logic              rw_q;
    logic [BW-1:0]     tx_shift;
    logic [BW-1:0]     rx_shift;

    logic          req_accept;
    logic          ack_ok;
    logic          tx_load;
    logic [BW-1:0] tx_byte;
    logic          tx_shift_en;
    logic          rx_shift_en;
    logic          frame_edge;  // start, repeated start or stop launch

    assign busy       = (state != S_IDLE);
    assign req_accept = (state == S_IDLE) && start;
    assign ack_ok     = (state == S_ACK) && high_mid && !sda_in;

    assign tx_shift_en = (state == S_TX) && low_mid && (bit_cnt != BITS_PER_BYTE);
    assign rx_shift_en = (state == S_RX) && high_mid;

    assign frame_edge = high_mid &&
        ((state == S_START) || (state == S_RSTART) || (state == S_STOP_HI));

    ////////////////////////////////////////////////////////////
    // next transmit byte
    ////////////////////////////////////////////////////////////

    always_comb begin
        tx_load = 1'b0;
        tx_byte = CTRL_WR;
        case (state)
            S_START: begin
                tx_load = high_mid;
            end
            S_RSTART: begin
                tx_load = high_mid;
                tx_byte = CTRL_RD;
            end
            S_ACK: begin
                if (ack_ok) begin
                    case (byte_idx)
                        2'd0: begin
                            tx_load = 1'b1;
                            // 24C64 ignores the top three bits
                            tx_byte = {{(2 * BW - ADDR_W){1'b0}}, addr_q[ADDR_W-1:BW]};
                        end
                        2'd1: begin
                            tx_load = 1'b1;
                            tx_byte = addr_q[BW-1:0];
                        end
                        2'd2: begin
                            tx_load = !rw_q;  // read goes to repeated start
                            tx_byte = wdata_q;
                        end
                        default: begin
                            tx_load = 1'b0;
                        end
                    endcase
                end
            end
            default: begin
                tx_load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (req_accept) begin
            addr_q  <= byte_addr;
            wdata_q <= wdata;
            rw_q    <= rw;
        end
        if (tx_load) begin
            tx_shift <= tx_byte;
        end else if (tx_shift_en) begin
            tx_shift <= {tx_shift[BW-2:0], 1'b0};  // msb first
        end
        if (rx_shift_en) begin
            rx_shift <= {rx_shift[BW-2:0], sda_in};
        end
    end

    ////////////////////////////////////////////////////////////
    // transaction FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            byte_idx <= '0;
            sda_oe   <= 1'b0;
            done     <= 1'b0;
            ack_err  <= 1'b0;
            rdata    <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        ack_err  <= 1'b0;
                        byte_idx <= 2'd0;
                        state    <= S_START;
                    end
                end
                S_START: begin
                    if (high_mid) begin
                        sda_oe  <= 1'b1;  // start condition
                        bit_cnt <= '0;
                        state   <= S_TX;
                    end
                end
                S_TX: begin
                    if (low_mid) begin
                        if (bit_cnt == BITS_PER_BYTE) begin
                            sda_oe <= 1'b0;  // hand sda to slave for ack
                            state  <= S_ACK;
                        end else begin
                            sda_oe  <= ~tx_shift[BW-1];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_ACK: begin
                    if (high_mid) begin
                        if (sda_in) begin
                            ack_err <= 1'b1;  // nack, abort with stop
                            state   <= S_STOP_LO;
                        end else if (tx_load) begin
                            byte_idx <= byte_idx + 1'b1;
                            bit_cnt  <= '0;
                            state    <= S_TX;
                        end else if (byte_idx == 2'd2) begin
                            state <= S_RSTART;  // dummy write finished
                        end else if (rw_q) begin
                            bit_cnt <= '0;
                            state   <= S_RX;
                        end else begin
                            state <= S_STOP_LO;
                        end
                    end
                end
                S_RSTART: begin
                    // sda released since the ack, so the low phase has passed high
                    if (high_mid) begin
                        sda_oe   <= 1'b1;
                        bit_cnt  <= '0;
                        byte_idx <= 2'd3;
                        state    <= S_TX;
                    end
                end
                S_RX: begin
                    if (high_mid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BITS_PER_BYTE - 1'b1) begin
                            rdata <= {rx_shift[BW-2:0], sda_in};
                            state <= S_NACK;
                        end
                    end
                end
                S_NACK: begin
                    if (high_mid) begin
                        state <= S_STOP_LO;  // slave has seen the nack
                    end
                end
                S_STOP_LO: begin
                    if (low_mid) begin
                        sda_oe <= 1'b1;
                        state  <= S_STOP_HI;
                    end
                end
                S_STOP_HI: begin
                    if (high_mid) begin
                        sda_oe <= 1'b0;  // stop condition
                        state  <= S_STOP_END;
                    end
                end
                S_STOP_END: begin
                    if (low_mid) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: begin
                    sda_oe <= 1'b0;
                    state  <= S_IDLE;
                end
            endcase
        end
    end

    // data moves only in scl low, framing only in scl high
    a_sda_oe_timing: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        $changed(sda_oe) |-> $past(low_mid) || $past(frame_edge)
    ) else $error("i2c_eeprom_master: sda_oe changed off a low_mid strobe");

    a_done_single: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        done |=> !done
    ) else $error("i2c_eeprom_master: done held for two cycles");

endmodule : i2c_eeprom_master

`default_nettype wire

//--- hdl/eeprom_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_access_top #(
    parameter int         SYS_CLK_HZ = 25_000_000,
    parameter int         SCL_HZ     = 1_000_000,
    parameter logic [2:0] DEV_SEL    = 3'b000
) (
    input  logic                                    sys_clk,
    input  logic                                    sys_rst_n,
    // host side
    input  logic                                    start,
    input  logic                                    rw,       // 1 = read
    input  logic [i2c_eeprom_pkg::EEPROM_ADDR_W-1:0] byte_addr,
    input  logic [i2c_eeprom_pkg::BYTE_W-1:0]        wdata,
    output logic                                    busy,
    output logic                                    done,
    output logic                                    ack_err,
    output logic [i2c_eeprom_pkg::BYTE_W-1:0]        rdata,
    // two-wire bus, pad resolved outside
    output logic                                    scl,
    output logic                                    sda_oe,   // 1 pulls sda low
    input  logic                                    sda_in
);

    localparam int CLK_DIV = SYS_CLK_HZ / SCL_HZ;

    logic high_mid;
    logic low_mid;

    ////////////////////////////////////////////////////////////
    // bit clock
    ////////////////////////////////////////////////////////////

    scl_timing_gen #(
        .CLK_DIV (CLK_DIV)
    ) scl_timing_gen_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .scl       (scl),
        .high_mid  (high_mid),
        .low_mid   (low_mid)
    );

    ////////////////////////////////////////////////////////////
    // byte transactions
    ////////////////////////////////////////////////////////////

    i2c_eeprom_master #(
        .DEV_SEL (DEV_SEL)
    ) i2c_eeprom_master_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start     (start),
        .rw        (rw),
        .byte_addr (byte_addr),
        .wdata     (wdata),
        .high_mid  (high_mid),
        .low_mid   (low_mid),
        .sda_in    (sda_in),
        .sda_oe    (sda_oe),
        .busy      (busy),
        .done      (done),
        .ack_err   (ack_err),
        .rdata     (rdata)
    );

endmodule : eeprom_access_top

`default_nettype wire

//--- tb/eeprom_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_slave_model #(
    parameter logic [2:0] DEV_SEL = 3'b000  // strap pins A2..A0
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic scl,
    input  logic sda,        // resolved bus level
    output logic sda_oe,     // 1 pulls sda low
    output logic proto_err
);

    localparam int MEM_DEPTH = 4096;
    localparam int BW        = i2c_eeprom_pkg::BYTE_W;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR_HI,
        M_ADDR_LO,
        M_WDATA,
        M_READ
    } mode_t;

    logic [BW-1:0] mem [0:MEM_DEPTH-1];

    mode_t                                   mode;
    logic [3:0]                              bit_cnt;   // bits done, 8 is the ack slot
    logic                                    bit_seen;  // scl rose since last fall
    logic [BW-1:0]                           shift_in;
    logic [BW-1:0]                           shift_out;
    logic [i2c_eeprom_pkg::EEPROM_ADDR_W-1:0] ptr;
    logic                                    scl_q;
    logic                                    sda_q;

    logic scl_rise;
    logic scl_fall;
    logic sda_edge_hi;

    assign scl_rise    = scl && !scl_q;
    assign scl_fall    = !scl && scl_q;
    assign sda_edge_hi = scl && scl_q && (sda != sda_q);

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;  // blank device
        end
    end

    always @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            mode      <= M_IDLE;
            bit_cnt   <= '0;
            bit_seen  <= 1'b0;
            shift_in  <= '0;
            shift_out <= '0;
            ptr       <= '0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            sda_oe    <= 1'b0;
            proto_err <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (sda_edge_hi) begin
                // framing is legal only on a byte boundary
                if (bit_cnt != 4'd0) begin
                    $display("eeprom model: SDA changed with SCL high inside a byte at %0t",
                             $time);
                    proto_err <= 1'b1;
                end else begin
                    mode     <= sda ? M_IDLE : M_CTRL;  // rise is stop, fall is start
                    bit_cnt  <= '0;
                    bit_seen <= 1'b0;
                    sda_oe   <= 1'b0;
                end
            end else if (scl_rise) begin
                bit_seen <= 1'b1;
                if (bit_cnt < 4'd8) begin
                    shift_in <= {shift_in[BW-2:0], sda};
                end
            end else if (scl_fall && bit_seen) begin
                bit_seen <= 1'b0;
                if (mode == M_IDLE) begin
                    bit_cnt <= '0;
                    sda_oe  <= 1'b0;
                end else if (bit_cnt == 4'd8) begin
                    bit_cnt <= '0;
                    sda_oe  <= (mode == M_READ) && !shift_out[BW-1];  // first read bit
                end else if (bit_cnt == 4'd7) begin
                    bit_cnt <= 4'd8;
                    sda_oe  <= 1'b1;  // ack unless changed below
                    case (mode)
                        M_CTRL: begin
                            if (shift_in[BW-1:1] != {i2c_eeprom_pkg::CTRL_CODE, DEV_SEL}) begin
                                sda_oe <= 1'b0;
                                mode   <= M_IDLE;
                            end else if (shift_in[0] == i2c_eeprom_pkg::RW_READ) begin
                                shift_out <= mem[ptr[11:0]];
                                mode      <= M_READ;
                            end else begin
                                mode <= M_ADDR_HI;
                            end
                        end
                        M_ADDR_HI: begin
                            // bit 12 lies beyond the array
                            if (shift_in[4]) begin
                                sda_oe <= 1'b0;
                                mode   <= M_IDLE;
                            end else begin
                                ptr[12:8] <= shift_in[4:0];
                                mode      <= M_ADDR_LO;
                            end
                        end
                        M_ADDR_LO: begin
                            ptr[7:0] <= shift_in;
                            mode     <= M_WDATA;
                        end
                        M_WDATA: begin
                            mem[ptr[11:0]] = shift_in;
                            mode <= M_IDLE;
                        end
                        default: begin
                            sda_oe <= 1'b0;  // read byte out, master owns the ack slot
                            mode   <= M_IDLE;
                        end
                    endcase
                end else begin
                    bit_cnt   <= bit_cnt + 4'd1;
                    shift_out <= {shift_out[BW-2:0], 1'b0};
                    sda_oe    <= (mode == M_READ) && !shift_out[BW-2];
                end
            end
        end
    end

endmodule : eeprom_slave_model

`default_nettype wire

//--- tb/tb_eeprom_access.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_access;

    localparam int         SYS_CLK_HZ      = 25_000_000;
    localparam int         SCL_HZ          = 1_000_000;
    localparam logic [2:0] DEV_SEL         = 3'b010;
    localparam int         CLK_DIV         = SYS_CLK_HZ / SCL_HZ;
    localparam int         PERIODS_PER_REQ = 60;  // scl periods allowed per request
    localparam int         ADDR_W          = i2c_eeprom_pkg::EEPROM_ADDR_W;
    localparam int         BW              = i2c_eeprom_pkg::BYTE_W;

    logic              sys_clk;
    logic              sys_rst_n;
    logic              start;
    logic              rw;
    logic [ADDR_W-1:0] byte_addr;
    logic [BW-1:0]     wdata;
    logic              busy;
    logic              done;
    logic              ack_err;
    logic [BW-1:0]     rdata;
    logic              scl;
    logic              sda_oe;
    logic              sda;
    logic              model_sda_oe;
    logic              proto_err;

    // requests and expected results from the stim file
    logic              op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    logic [BW-1:0]     wdata_q[$];
    logic              err_q[$];
    logic [BW-1:0]     rdata_exp_q[$];

    int     cycle_cnt;
    int     cycle_limit;
    int     done_cnt;
    integer seed;

    assign sda = !(sda_oe || model_sda_oe);  // open-drain wired-AND

    eeprom_access_top #(
        .SYS_CLK_HZ (SYS_CLK_HZ),
        .SCL_HZ     (SCL_HZ),
        .DEV_SEL    (DEV_SEL)
    ) eeprom_access_top_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start     (start),
        .rw        (rw),
        .byte_addr (byte_addr),
        .wdata     (wdata),
        .busy      (busy),
        .done      (done),
        .ack_err   (ack_err),
        .rdata     (rdata),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda)
    );

    eeprom_slave_model #(
        .DEV_SEL (DEV_SEL)
    ) eeprom_slave_model_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .scl       (scl),
        .sda       (sda),
        .sda_oe    (model_sda_oe),
        .proto_err (proto_err)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    ////////////////////////////////////////////////////////////
    // checks and monitors
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: no verdict after %0d clock cycles", cycle_cnt);
            $display("Simulation FAILED");
            $fatal(1, "run exceeded its cycle limit");
        end
    end

    always @(negedge sys_clk) begin
        if (proto_err) begin
            $display("Simulation FAILED");
            $fatal(1, "EEPROM model saw SDA move while SCL was high inside a byte");
        end
    end

    always @(negedge sys_clk) begin
        if (done === 1'b1) begin
            done_cnt <= done_cnt + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic load_requests;
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wd;
        logic [31:0] f_err;
        logic [31:0] f_rd;
        fd = $fopen("tb/eeprom_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/eeprom_stim.txt");
            $display("Simulation FAILED");
            $fatal(1, "stim file missing");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // comment and blank lines do not scan
            if (code != 0 &&
                $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_wd, f_err, f_rd) == 5) begin
                op_q.push_back(f_op[0]);
                addr_q.push_back(f_addr[ADDR_W-1:0]);
                wdata_q.push_back(f_wd[BW-1:0]);
                err_q.push_back(f_err[0]);
                rdata_exp_q.push_back(f_rd[BW-1:0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_request(input int idx);
        logic [31:0] rnd;
        rnd = $random(seed);
        repeat (rnd[3:0]) @(posedge sys_clk);  // idle gap
        @(posedge sys_clk);
        start     <= 1'b1;
        rw        <= op_q[idx];
        byte_addr <= addr_q[idx];
        wdata     <= wdata_q[idx];
        @(posedge sys_clk);
        start <= 1'b0;
        @(negedge sys_clk);
        check_value("busy", busy, 1);
        // strobe again with other values while busy, must be ignored
        @(posedge sys_clk);
        start     <= 1'b1;
        rw        <= !op_q[idx];
        byte_addr <= ~addr_q[idx];
        wdata     <= ~wdata_q[idx];
        @(posedge sys_clk);
        start <= 1'b0;
        @(negedge sys_clk);
        while (done !== 1'b1) begin
            @(negedge sys_clk);
        end
        check_value("busy", busy, 0);
        check_value("ack_err", ack_err, err_q[idx]);
        if (op_q[idx] && !err_q[idx]) begin
            check_value("rdata", rdata, rdata_exp_q[idx]);
        end
    endtask

    initial begin
        sys_rst_n   = 1'b0;
        start       = 1'b0;
        rw          = 1'b0;
        byte_addr   = '0;
        wdata       = '0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        done_cnt    = 0;
        seed        = 32'hb295_d3e1;
        load_requests();
        if (op_q.size() == 0) begin
            $display("stim file holds no requests");
            $display("Simulation FAILED");
            $fatal(1, "empty stim file");
        end
        cycle_limit = op_q.size() * PERIODS_PER_REQ * CLK_DIV;
        repeat (5) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(negedge sys_clk);
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("ack_err", ack_err, 0);
        check_value("sda_oe", sda_oe, 0);
        check_value("scl", scl, 1);
        for (int i = 0; i < op_q.size(); i++) begin
            run_request(i);
        end
        repeat (PERIODS_PER_REQ * CLK_DIV) @(negedge sys_clk);  // room for a stray transfer
        check_value("done_count", done_cnt, op_q.size());
        $display("Simulation PASSED");
        $finish;
    end

endmodule : tb_eeprom_access

`default_nettype wire

//--- all.f
hdl/i2c_eeprom_pkg.sv
hdl/scl_timing_gen.sv
hdl/i2c_eeprom_master.sv
hdl/eeprom_access_top.sv
tb/eeprom_slave_model.sv
tb/tb_eeprom_access.sv

//--- run_sim.sh
#!/bin/sh
# build the EEPROM controller testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_eeprom_access \
    -f all.f -o tb_eeprom_access \
    && ./obj_dir/tb_eeprom_access \
    || { echo "run_sim: build or simulation failed"; exit 1; }

//--- tb/eeprom_stim.txt
# op addr wdata exp_ack_err exp_rdata, all hex; op 0 is a write, op 1 a read
# rdata is compared only on reads that finish without ack_err
0 0000 5a 0 00
1 0000 00 0 5a
0 0123 c3 0 00
1 0123 00 0 c3
0 0fff 81 0 00
1 0fff 00 0 81
1 0000 00 0 5a
1 0456 00 0 00
0 1005 aa 1 00
1 0005 00 0 00
1 1123 00 1 00
1 0123 00 0 c3
0 0005 3c 0 00
1 0005 00 0 3c
1 0fff 00 0 81
1 0800 00 0 00
